/* all.f */
armControlPkg.sv
instrDecoder.sv
condUnit.sv
executeStage.sv
memWbStage.sv
armController.sv
armController_tb.sv

/* armControlPkg.sv */
`default_nettype none

package armControlPkg;

  // ==========================================================================
  // Instruction encodings
  // ==========================================================================

  // Data-processing opcode, value is instr[24:21]
  typedef enum logic [3:0] {
    opAnd = 4'b0000, opEor, opSub, opRsb,
    opAdd, opAdc, opSbc, opRsc,
    opTst, opTeq, opCmp, opCmn,
    opOrr, opMov, opBic, opMvn
  } aluOp_t;

  // Condition field, instr[31:28]
  typedef enum logic [3:0] {
    condEq = 4'b0000, condNe, condCs, condCc,
    condMi, condPl, condVs, condVc,
    condHi, condLs, condGe, condLt,
    condGt, condLe, condAl, condNv
  } condCode_t;

  // Major class from instr[27:26]
  typedef enum logic [1:0] {
    clsDataProc  = 2'b00,
    clsLoadStore = 2'b01,
    clsBranch    = 2'b10,
    clsReserved  = 2'b11   // Decoded as a no-op
  } instrClass_t;

  localparam logic [3:0] pcReg = 4'd15;  // Rd of R15 means a PC write

  // ==========================================================================
  // Control bundles per stage
  // ==========================================================================

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flags_t;

  typedef struct packed {
    logic [1:0] regSrc;  // [0] PC as Rn, [1] Rd on second read port
    logic [1:0] immSrc;  // 00 rotated imm8, 01 imm12, 10 imm24
  } decodeCtrl_t;

  typedef struct packed {
    logic   aluSrc;      // Immediate as ALU operand B
    aluOp_t aluControl;
    logic   memtoReg;    // Load result to register file
    logic   lsByte;      // Byte access
    logic   isStore;
  } exCtrl_t;

  typedef struct packed {
    logic       memWrite;
    logic [3:0] byteMask;  // One bit per byte lane
  } memCtrl_t;

  typedef struct packed {
    logic memtoReg;
    logic regWrite;
    logic pcSrc;
    logic loadByte;
  } wbCtrl_t;

  // Raw Decode outputs, captured by the Execute register
  typedef struct packed {
    logic       regWrite;
    logic       memWrite;
    logic       branch;
    logic       pcSrc;
    logic [1:0] flagWrite;   // [1] NZ, [0] CV
    logic       doNotWrite;  // Compare ops, flags only
    condCode_t  cond;
    exCtrl_t    ex;
  } decodeBundle_t;

endpackage

`default_nettype wire

/* armController.sv */
`timescale 1ns/1ps
`default_nettype none

module armController (
  input  logic                       clk,
  input  logic                       reset,         // Synchronous, active high
  input  logic [31:0]                instrD,
  input  armControlPkg::flags_t      aluFlagsE,     // From the datapath ALU
  input  logic [1:0]                 addrLowE,      // Execute ALU result bits 1:0
  input  logic                       stallE,
  input  logic                       flushE,
  input  logic                       stallM,
  input  logic                       stallW,
  input  logic                       flushW,
  output armControlPkg::decodeCtrl_t decD,
  output armControlPkg::exCtrl_t     exE,
  output logic                       branchTakenE,
  output armControlPkg::flags_t      flagsE,
  output armControlPkg::memCtrl_t    memM,
  output armControlPkg::wbCtrl_t     wbW,
  output logic                       pcWrPending    // Any PC write in D, E or M
);

  armControlPkg::decodeBundle_t decBundle;
  armControlPkg::condCode_t     condE;
  armControlPkg::memCtrl_t      memGated;
  armControlPkg::wbCtrl_t       wbGated;
  armControlPkg::flags_t        nextFlagsE, nextFlagsM, nextFlagsW, archFlags;
  logic [1:0]                   flagWriteE;
  logic                         condEx, setFlagsE, setFlagsM, setFlagsW;
  logic                         pcSrcE, pcSrcM;

  instrDecoder decoder (.instrD(instrD), .decBundle(decBundle), .dec(decD));

  executeStage exStage (.clk(clk), .reset(reset), .stallE(stallE), .flushE(flushE),
    .decBundle(decBundle), .condEx(condEx), .addrLowE(addrLowE), .exE(exE),
    .condE(condE), .flagWriteE(flagWriteE), .branchTakenE(branchTakenE),
    .memGated(memGated), .wbGated(wbGated), .pcSrcE(pcSrcE));

  condUnit condCheck (.condE(condE), .flagWriteE(flagWriteE), .aluFlagsE(aluFlagsE),
    .nextFlagsM(nextFlagsM), .setFlagsM(setFlagsM), .nextFlagsW(nextFlagsW),
    .setFlagsW(setFlagsW), .archFlags(archFlags), .flagsE(flagsE), .condEx(condEx),
    .nextFlagsE(nextFlagsE), .setFlagsE(setFlagsE));

  memWbStage lateStages (.clk(clk), .reset(reset), .stallM(stallM), .stallW(stallW),
    .flushW(flushW), .memGated(memGated), .wbGated(wbGated), .nextFlagsE(nextFlagsE),
    .setFlagsE(setFlagsE), .memM(memM), .wbW(wbW), .nextFlagsM(nextFlagsM),
    .setFlagsM(setFlagsM), .nextFlagsW(nextFlagsW), .setFlagsW(setFlagsW),
    .archFlags(archFlags), .pcSrcM(pcSrcM));

  assign pcWrPending = decBundle.pcSrc | pcSrcE | pcSrcM;  // Fetch waits on these

endmodule

`default_nettype wire

/* armController_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module armController_tb;

  localparam int clkPeriod   = 40;
  localparam int resetCycles = 4;
  localparam int maxVectors  = 64;    // Room for the stimulus file

  logic                       clk;
  logic                       reset;
  logic [31:0]                instrD;
  armControlPkg::flags_t      aluFlagsE;
  logic [1:0]                 addrLowE;
  logic                       stallE;
  logic                       flushE;
  logic                       stallM;
  logic                       stallW;
  logic                       flushW;
  armControlPkg::decodeCtrl_t decD;
  armControlPkg::exCtrl_t     exE;
  logic                       branchTakenE;
  armControlPkg::flags_t      flagsE;
  armControlPkg::memCtrl_t    memM;
  armControlPkg::wbCtrl_t     wbW;
  logic                       pcWrPending;

  // Vector table with one entry per clock cycle
  logic [3:0]  vecTest   [0:maxVectors-1];  // Behavior id
  logic [31:0] vecInstr  [0:maxVectors-1];
  logic [3:0]  vecAlu    [0:maxVectors-1];
  logic [1:0]  vecAddr   [0:maxVectors-1];
  logic [4:0]  vecCtl    [0:maxVectors-1];  // stallE flushE stallM stallW flushW
  logic [3:0]  vecFlags  [0:maxVectors-1];
  logic        vecBranch [0:maxVectors-1];
  logic [7:0]  vecEx     [0:maxVectors-1];
  logic [4:0]  vecMem    [0:maxVectors-1];
  logic [3:0]  vecWb     [0:maxVectors-1];

  // PC write model for Execute and Memory
  logic        pcWrE;
  logic        pcWrM;
  logic [3:0]  condInE;                     // Condition field of the Execute instr

  int numVectors = 0;
  int errorCount = 0;
  int checkCount = 0;
  int cycleCount = 0;
  int cycleLimit = maxVectors + 20;
  int idx;

  armController armController_i (.clk(clk), .reset(reset), .instrD(instrD),
    .aluFlagsE(aluFlagsE), .addrLowE(addrLowE), .stallE(stallE), .flushE(flushE),
    .stallM(stallM), .stallW(stallW), .flushW(flushW), .decD(decD), .exE(exE),
    .branchTakenE(branchTakenE), .flagsE(flagsE), .memM(memM), .wbW(wbW),
    .pcWrPending(pcWrPending));

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  // ==========================================================================
  // Timeout watchdog
  // ==========================================================================
  always @(posedge clk) begin
    if (!reset) cycleCount <= cycleCount + 1;   // Only cycles past reset
    if (cycleCount > cycleLimit) begin
      $display("Timeout, run still going after %0d cycles", cycleCount);
      $display("Simulation failed");
      $finish;
    end
  end

  function string behaviorLabel(input logic [3:0] id);
    case (id)
      4'd1:    behaviorLabel = "flag forwarding";
      4'd2:    behaviorLabel = "conditional execution";
      4'd3:    behaviorLabel = "compare and logical flags";
      4'd4:    behaviorLabel = "store lanes and byte load";
      4'd5:    behaviorLabel = "stall, flush and reset";
      default: behaviorLabel = "unnamed";
    endcase
  endfunction

  // ==========================================================================
  // Reference rules from the instruction set
  // ==========================================================================

  // Expected {regSrc, immSrc} per instruction class
  function automatic logic [3:0] decodeCtrlFor(input logic [31:0] instr);
    case (instr[27:26])
      2'b00:   decodeCtrlFor = 4'b00_00;                         // Registers, rotated imm8
      2'b01:   decodeCtrlFor = instr[20] ? 4'b00_01 : 4'b10_01;  // Store data from Rd
      2'b10:   decodeCtrlFor = 4'b01_10;                         // PC as Rn, imm24
      default: decodeCtrlFor = 4'b00_00;
    endcase
  endfunction

  // B always redirects, others only with Rd of R15
  function automatic logic pcWriteInDecode(input logic [31:0] instr);
    logic toPc;
    toPc = (instr[15:12] == armControlPkg::pcReg);
    case (instr[27:26])
      2'b00:   pcWriteInDecode = toPc && (instr[24:23] != 2'b10);  // TST to CMN write nothing
      2'b01:   pcWriteInDecode = toPc && instr[20];                // Loads only
      2'b10:   pcWriteInDecode = 1'b1;
      default: pcWriteInDecode = 1'b0;
    endcase
  endfunction

  // ARM condition codes on NZCV
  function automatic logic conditionPasses(input logic [3:0] cond, input logic [3:0] nzcv);
    logic n;
    logic z;
    logic c;
    logic v;
    {n, z, c, v} = nzcv;
    case (cond)
      4'h0:    conditionPasses = z;                 // EQ
      4'h1:    conditionPasses = !z;
      4'h2:    conditionPasses = c;                 // CS
      4'h3:    conditionPasses = !c;
      4'h4:    conditionPasses = n;                 // MI
      4'h5:    conditionPasses = !n;
      4'h6:    conditionPasses = v;
      4'h7:    conditionPasses = !v;
      4'h8:    conditionPasses = c && !z;           // HI
      4'h9:    conditionPasses = !c || z;
      4'hA:    conditionPasses = (n == v);          // GE
      4'hB:    conditionPasses = (n != v);
      4'hC:    conditionPasses = !z && (n == v);
      4'hD:    conditionPasses = z || (n != v);
      4'hE:    conditionPasses = 1'b1;              // AL
      default: conditionPasses = 1'b0;              // NV never passes
    endcase
  endfunction

  // Comment lines fail the scan and are skipped
  task loadVectors;
    int               fd;
    int               code;
    logic [8*128-1:0] lineBuf;
    logic [31:0]      tId, tInstr, tAlu, tAddr, tSe, tFe, tSm, tSw, tFw;
    logic [31:0]      tFlags, tBr, tEx, tMem, tWb;
    fd = $fopen("controller_stimulus.txt", "r");
    if (fd == 0) begin
      errorCount++;
      $display("Could not open controller_stimulus.txt for reading");
    end else begin
      while ($fgets(lineBuf, fd) != 0 && numVectors < maxVectors) begin
        code = $sscanf(lineBuf, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
          tId, tInstr, tAlu, tAddr, tSe, tFe, tSm, tSw, tFw, tFlags, tBr, tEx, tMem, tWb);
        if (code == 14) begin
          vecTest[numVectors]   = tId[3:0];
          vecInstr[numVectors]  = tInstr;
          vecAlu[numVectors]    = tAlu[3:0];
          vecAddr[numVectors]   = tAddr[1:0];
          vecCtl[numVectors]    = {tSe[0], tFe[0], tSm[0], tSw[0], tFw[0]};
          vecFlags[numVectors]  = tFlags[3:0];
          vecBranch[numVectors] = tBr[0];
          vecEx[numVectors]     = tEx[7:0];
          vecMem[numVectors]    = tMem[4:0];
          vecWb[numVectors]     = tWb[3:0];
          numVectors++;
        end
      end
      $fclose(fd);
      if (numVectors == 0) begin
        errorCount++;
        $display("No usable vector lines in controller_stimulus.txt");
      end
    end
  endtask

  task checkField(input string label, input string field, input logic [7:0] expected,
                  input logic [7:0] actual);
    checkCount++;
    assert (actual === expected) else begin
      errorCount++;
      $display("mismatch %s, %s: expected %h, actual %h", label, field, expected, actual);
    end
  endtask

  task checkReset;
    checkField("reset", "exE", 8'h00, exE);
    checkField("reset", "memM", 8'h00, memM);
    checkField("reset", "wbW", 8'h00, wbW);
    checkField("reset", "flagsE", 8'h00, flagsE);          // Architectural flags cleared
    checkField("reset", "branchTakenE", 8'h00, branchTakenE);
    checkField("reset", "decD", 8'h00, decD);              // instrD held at zero
    checkField("reset", "pcWrPending", 8'h00, pcWrPending);
  endtask

  task applyVector(input int n);
    instrD    = vecInstr[n];
    aluFlagsE = vecAlu[n];                                 // Flags of the Execute instr
    addrLowE  = vecAddr[n];
    {stallE, flushE, stallM, stallW, flushW} = vecCtl[n];
  endtask

  task checkVector(input int n);
    string label;
    label = $sformatf("%s, vector %0d", behaviorLabel(vecTest[n]), n);
    checkField(label, "flagsE", vecFlags[n], flagsE);
    checkField(label, "branchTakenE", vecBranch[n], branchTakenE);
    checkField(label, "exE", vecEx[n], exE);
    checkField(label, "memM", vecMem[n], memM);
    checkField(label, "wbW", vecWb[n], wbW);
    checkField(label, "decD", decodeCtrlFor(vecInstr[n]), decD);
    checkField(label, "pcWrPending", pcWriteInDecode(vecInstr[n]) | pcWrE | pcWrM,
               pcWrPending);
  endtask

  // Steps the PC write model across one rising edge
  task advancePcModel(input int n);
    if (!stallM) begin
      pcWrM = pcWrE && conditionPasses(condInE, vecFlags[n]);  // Memory sees gated pcSrc
    end
    if (flushE) begin
      pcWrE   = 1'b0;
      condInE = 4'h0;
    end else if (!stallE) begin
      pcWrE   = pcWriteInDecode(vecInstr[n]);
      condInE = vecInstr[n][31:28];
    end
  endtask

  // ==========================================================================
  // Main sequence
  // ==========================================================================
  initial begin
    reset     = 1'b1;
    instrD    = '0;
    aluFlagsE = '0;
    addrLowE  = '0;
    stallE    = 1'b0;
    flushE    = 1'b0;
    stallM    = 1'b0;
    stallW    = 1'b0;
    flushW    = 1'b0;
    pcWrE     = 1'b0;
    pcWrM     = 1'b0;
    condInE   = 4'h0;
    loadVectors();
    cycleLimit = numVectors + 20;                          // Drain margin past the vectors
    if (numVectors > 0) begin
      repeat (resetCycles) @(posedge clk);
      @(negedge clk);
      checkReset();
      reset = 1'b0;
      for (idx = 0; idx < numVectors; idx++) begin
        applyVector(idx);                                  // Falling edge drive
        #(clkPeriod / 2 - 1);                              // Just before the rising edge
        checkVector(idx);
        advancePcModel(idx);
        @(negedge clk);
      end
    end
    $display("Summary: %0d vectors, %0d checks, %0d errors", numVectors, checkCount,
             errorCount);
    if (errorCount == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* condUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module condUnit (
  input  armControlPkg::condCode_t condE,       // Condition of the Execute instruction
  input  logic [1:0]               flagWriteE,  // [1] NZ, [0] CV
  input  armControlPkg::flags_t    aluFlagsE,   // Raw ALU flags
  input  armControlPkg::flags_t    nextFlagsM,
  input  logic                     setFlagsM,
  input  armControlPkg::flags_t    nextFlagsW,
  input  logic                     setFlagsW,
  input  armControlPkg::flags_t    archFlags,   // Committed NZCV
  output armControlPkg::flags_t    flagsE,      // Flags seen by Execute
  output logic                     condEx,      // Condition passed
  output armControlPkg::flags_t    nextFlagsE,
  output logic                     setFlagsE
);

  logic ge;  // Signed greater or equal

  // ==========================================================================
  // Flag forwarding
  // ==========================================================================
  // Youngest flag setter wins, committed flags last
  assign flagsE = setFlagsM ? nextFlagsM : (setFlagsW ? nextFlagsW : archFlags);
  assign ge     = (flagsE.n == flagsE.v);

  // ==========================================================================
  // Condition check
  // ==========================================================================
  always_comb begin
    unique case (condE)
      armControlPkg::condEq: condEx = flagsE.z;
      armControlPkg::condNe: condEx = ~flagsE.z;
      armControlPkg::condCs: condEx = flagsE.c;
      armControlPkg::condCc: condEx = ~flagsE.c;
      armControlPkg::condMi: condEx = flagsE.n;
      armControlPkg::condPl: condEx = ~flagsE.n;
      armControlPkg::condVs: condEx = flagsE.v;
      armControlPkg::condVc: condEx = ~flagsE.v;
      armControlPkg::condHi: condEx = flagsE.c & ~flagsE.z;    // Unsigned higher
      armControlPkg::condLs: condEx = ~flagsE.c | flagsE.z;
      armControlPkg::condGe: condEx = ge;
      armControlPkg::condLt: condEx = ~ge;
      armControlPkg::condGt: condEx = ~flagsE.z & ge;
      armControlPkg::condLe: condEx = flagsE.z | ~ge;
      armControlPkg::condAl: condEx = 1'b1;
      armControlPkg::condNv: condEx = 1'b0;                    // Never
    endcase
  end

  // ==========================================================================
  // Next flags
  // ==========================================================================
  always_comb begin
    nextFlagsE = flagsE;                // Untouched pairs carry forward
    if (flagWriteE[1]) begin
      nextFlagsE.n = aluFlagsE.n;
      nextFlagsE.z = aluFlagsE.z;
    end
    if (flagWriteE[0]) begin
      nextFlagsE.c = aluFlagsE.c;
      nextFlagsE.v = aluFlagsE.v;
    end
  end

  assign setFlagsE = (|flagWriteE) & condEx;  // Failed condition leaves flags alone

endmodule

`default_nettype wire

/* controller_stimulus.txt */
# id instrD aluFlagsE addrLowE stallE flushE stallM stallW flushW (inputs, hex)
# then expected flagsE branchTakenE exE memM wbW (hex), one line per clock cycle
5 EC000000 0 0 0 0 0 0 0 0 0 00 00 0
1 E0921003 0 0 0 0 0 0 0 0 0 00 00 0
1 42844001 A 0 0 0 0 0 0 0 0 20 00 0
1 22855001 0 0 0 0 0 0 0 A 0 A0 00 0
1 EC000000 0 0 0 0 0 0 0 A 0 A0 00 4
3 E1510002 0 0 0 0 0 0 0 A 0 00 00 4
3 02811001 2 0 0 0 0 0 0 A 0 50 00 4
2 05832004 0 0 0 0 0 0 0 2 0 A0 00 0
2 0A000004 0 0 0 0 0 0 0 2 0 A1 00 0
2 EC000000 0 0 0 0 0 0 0 2 0 A0 00 0
3 E1110002 0 0 0 0 0 0 0 2 0 00 00 0
2 0A000004 5 0 0 0 0 0 0 2 0 40 00 0
2 EC000000 0 0 0 0 0 0 0 6 1 A0 00 0
3 EC000000 0 0 0 0 0 0 0 6 0 00 00 0
2 E5C32001 0 0 0 0 0 0 0 6 0 00 00 2
4 E5032004 0 2 0 0 0 0 0 6 0 A3 00 0
4 E5D34002 0 3 0 0 0 0 0 6 0 91 14 0
4 EC000000 0 0 0 0 0 0 0 6 0 A6 1F 0
4 EC000000 0 0 0 0 0 0 0 6 0 00 00 0
4 E2866001 0 0 0 0 0 0 0 6 0 00 00 D
5 E5832004 0 0 1 0 0 0 0 6 0 A0 00 0
5 E5832004 0 0 0 0 0 0 0 6 0 A0 00 0
5 E2877001 0 1 0 1 0 0 0 6 0 A1 00 4
5 EC000000 0 0 0 0 0 0 0 6 0 00 1F 4
5 EC000000 0 0 0 0 0 0 0 6 0 00 00 0
5 EC000000 0 0 0 0 0 0 0 6 0 00 00 0

/* executeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module executeStage (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         stallE,        // Hold the Execute register
  input  logic                         flushE,        // Bubble into Execute
  input  armControlPkg::decodeBundle_t decBundle,     // From the decoder
  input  logic                         condEx,        // From condUnit
  input  logic [1:0]                   addrLowE,      // ALU result bits 1:0
  output armControlPkg::exCtrl_t       exE,           // Datapath selects in Execute
  output armControlPkg::condCode_t     condE,
  output logic [1:0]                   flagWriteE,
  output logic                         branchTakenE,
  output armControlPkg::memCtrl_t      memGated,      // Toward the Memory register
  output armControlPkg::wbCtrl_t       wbGated,       // Toward the Memory register
  output logic                         pcSrcE         // Ungated, for PC hazard detection
);

  armControlPkg::decodeBundle_t bundleE;
  logic                         regWriteGated;
  logic                         memWriteGated;
  logic                         pcSrcGated;
  logic [3:0]                   byteLane;
  logic [3:0]                   storeLanes;

  // ==========================================================================
  // Decode to Execute register
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (reset || flushE) begin
      bundleE <= '0;           // Flush has priority over stall
    end else if (!stallE) begin
      bundleE <= decBundle;
    end
  end

  assign exE        = bundleE.ex;
  assign condE      = bundleE.cond;
  assign flagWriteE = bundleE.flagWrite;
  assign pcSrcE     = bundleE.pcSrc;

  // ==========================================================================
  // Condition gating
  // ==========================================================================
  assign regWriteGated = bundleE.regWrite & condEx & ~bundleE.doNotWrite; // Compares write none
  assign memWriteGated = bundleE.memWrite & condEx;
  assign pcSrcGated    = bundleE.pcSrc & condEx;
  assign branchTakenE  = bundleE.branch & condEx;

  // Store lanes, byte store picks one lane by address
  assign byteLane   = 4'b0001 << addrLowE;
  assign storeLanes = bundleE.ex.lsByte ? byteLane : 4'b1111;

  always_comb begin
    memGated.memWrite = memWriteGated;
    memGated.byteMask = memWriteGated ? storeLanes : 4'b0000;  // Quiet when no write
    wbGated.memtoReg  = bundleE.ex.memtoReg;
    wbGated.regWrite  = regWriteGated;
    wbGated.pcSrc     = pcSrcGated;
    wbGated.loadByte  = bundleE.ex.lsByte & bundleE.ex.memtoReg;  // LDRB zero-extends
  end

endmodule

`default_nettype wire

/* instrDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
  input  logic [31:0]                  instrD,     // Instruction in Decode
  output armControlPkg::decodeBundle_t decBundle,  // Raw controls toward Execute
  output armControlPkg::decodeCtrl_t   dec         // Decode-stage datapath selects
);

  armControlPkg::instrClass_t instrClass;
  armControlPkg::aluOp_t      dpOp;
  logic                       immForm;    // I bit, meaning differs per class
  logic                       sBit;       // Set flags on data processing
  logic                       loadBit;    // L bit on load/store, same position as S
  logic                       logicalOp;
  logic                       compareOp;

  assign instrClass = armControlPkg::instrClass_t'(instrD[27:26]);
  assign dpOp       = armControlPkg::aluOp_t'(instrD[24:21]);
  assign immForm    = instrD[25];
  assign sBit       = instrD[20];
  assign loadBit    = instrD[20];

  // ==========================================================================
  // Opcode groups
  // ==========================================================================
  always_comb begin
    logicalOp = 1'b0;
    compareOp = 1'b0;
    unique case (dpOp)
      armControlPkg::opAnd, armControlPkg::opEor,
      armControlPkg::opOrr, armControlPkg::opMov,
      armControlPkg::opBic, armControlPkg::opMvn: logicalOp = 1'b1;
      armControlPkg::opTst, armControlPkg::opTeq: begin
        logicalOp = 1'b1;  // Test ops are logical and compare
        compareOp = 1'b1;
      end
      armControlPkg::opCmp, armControlPkg::opCmn: compareOp = 1'b1;
      default: ;           // Arithmetic, writes a result
    endcase
  end

  // ==========================================================================
  // Main decode
  // ==========================================================================
  always_comb begin
    decBundle = '0;  // Reserved class leaves everything cleared
    dec       = '0;
    unique case (instrClass)
      armControlPkg::clsDataProc: begin
        decBundle.ex.aluSrc     = immForm;                   // Rotated imm8 form
        decBundle.ex.aluControl = dpOp;
        decBundle.regWrite      = 1'b1;
        decBundle.flagWrite     = {sBit, sBit & ~logicalOp}; // Logical ops keep C and V
        decBundle.doNotWrite    = compareOp;
      end
      armControlPkg::clsLoadStore: begin
        dec.regSrc              = loadBit ? 2'b00 : 2'b10;   // Store data read from Rd
        dec.immSrc              = 2'b01;
        decBundle.ex.aluSrc     = ~immForm;                  // I set means register offset
        decBundle.ex.aluControl = instrD[23] ? armControlPkg::opAdd : armControlPkg::opSub;
        decBundle.ex.memtoReg   = loadBit;
        decBundle.ex.lsByte     = instrD[22];                // B bit
        decBundle.ex.isStore    = ~loadBit;
        decBundle.regWrite      = loadBit;
        decBundle.memWrite      = ~loadBit;
      end
      armControlPkg::clsBranch: begin
        dec.regSrc              = 2'b01;                     // PC plus offset
        dec.immSrc              = 2'b10;
        decBundle.ex.aluSrc     = 1'b1;
        decBundle.ex.aluControl = armControlPkg::opAdd;
        decBundle.branch        = 1'b1;
      end
      default: ;                                             // No-op
    endcase
    if (instrClass != armControlPkg::clsReserved) begin
      decBundle.cond = armControlPkg::condCode_t'(instrD[31:28]);
    end
    // PC redirect for B or a real write to R15
    decBundle.pcSrc = decBundle.branch | (decBundle.regWrite & ~decBundle.doNotWrite &
                      (instrD[15:12] == armControlPkg::pcReg));
  end

endmodule

`default_nettype wire

/* memWbStage.sv */
`timescale 1ns/1ps
`default_nettype none

module memWbStage (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    stallM,      // Hold the Memory register
  input  logic                    stallW,      // Hold the Writeback register
  input  logic                    flushW,      // Bubble into Writeback
  input  armControlPkg::memCtrl_t memGated,
  input  armControlPkg::wbCtrl_t  wbGated,
  input  armControlPkg::flags_t   nextFlagsE,
  input  logic                    setFlagsE,
  output armControlPkg::memCtrl_t memM,
  output armControlPkg::wbCtrl_t  wbW,
  output armControlPkg::flags_t   nextFlagsM,
  output logic                    setFlagsM,
  output armControlPkg::flags_t   nextFlagsW,
  output logic                    setFlagsW,
  output armControlPkg::flags_t   archFlags,   // Committed NZCV
  output logic                    pcSrcM
);

  armControlPkg::wbCtrl_t wbM;  // Writeback controls riding through Memory

  // ==========================================================================
  // Execute to Memory register
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      memM       <= '0;
      wbM        <= '0;
      setFlagsM  <= 1'b0;
      nextFlagsM <= '0;
    end else if (!stallM) begin    // No flush on this stage
      memM       <= memGated;
      wbM        <= wbGated;
      setFlagsM  <= setFlagsE;
      nextFlagsM <= nextFlagsE;
    end
  end

  assign pcSrcM = wbM.pcSrc;

  // ==========================================================================
  // Memory to Writeback register
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (reset || flushW) begin
      wbW        <= '0;
      setFlagsW  <= 1'b0;
      nextFlagsW <= '0;
    end else if (!stallW) begin
      wbW        <= wbM;
      setFlagsW  <= setFlagsM;
      nextFlagsW <= nextFlagsM;
    end
  end

  // Architectural flags written in Writeback
  always_ff @(posedge clk) begin
    if (reset) begin
      archFlags <= '0;
    end else if (setFlagsW && !stallW) begin
      archFlags <= nextFlagsW;
    end
  end

endmodule

`default_nettype wire
